// ==== src.f ====
+incdir+bench
rtl/core_pkg.sv
rtl/bus_pkg.sv
rtl/branch_pred.sv
rtl/fetch_unit.sv
rtl/wb_arbiter.sv
rtl/inst_mem.sv
rtl/fetch_top.sv
bench/fetch_tb.sv

// ==== bench/fetch_model.svh ====
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// Mirror of instruction memory and predictor tables
logic [XLEN-1:0] model_mem [MEM_WORDS];
logic [XLEN-1:0] model_target [BTB_ENTRIES];
logic            model_valid [BTB_ENTRIES];
logic [1:0]      model_pht [BTB_ENTRIES];
logic [XLEN-1:0] model_pc;

function automatic int unsigned table_index(input logic [XLEN-1:0] pc);
    return (pc >> 2) % BTB_ENTRIES;
endfunction

function automatic int unsigned mem_index(input logic [XLEN-1:0] adr);
    return (adr >> 2) % MEM_WORDS;
endfunction

// Weakly not taken, no targets
function automatic void reset_model();
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        model_valid[i] = 1'b0;
        model_pht[i]   = 2'd1;
    end
    model_pc = '0;
endfunction

// One committed lane, saturating 2-bit count
function automatic void train(input branch_update_t upd);
    int unsigned idx;
    idx = table_index(upd.pc);
    if (upd.valid) begin
        if (upd.taken) begin
            model_target[idx] = upd.target;
            model_valid[idx]  = 1'b1;
            if (model_pht[idx] < 2'd3) begin
                model_pht[idx] = model_pht[idx] + 2'd1;
            end
        end else if (model_pht[idx] > 2'd0) begin
            model_pht[idx] = model_pht[idx] - 2'd1;
        end
    end
endfunction

// Packet a group starting at pc should produce
function automatic fetch_packet_t expected_packet(input logic [XLEN-1:0] pc);
    fetch_packet_t pkt;
    int unsigned   idx;
    logic          found;
    pkt.pc          = pc;
    pkt.next_pc     = pc + 4 * WAYS;
    pkt.predictions = '0;
    pkt.lane_valid  = '0;
    found           = 1'b0;
    for (int i = 0; i < WAYS; i++) begin
        pkt.insts[i]      = model_mem[((pc >> 2) + i) % MEM_WORDS];
        pkt.lane_valid[i] = !found;
        idx = (table_index(pc) + i) % BTB_ENTRIES;
        if (!found && model_pht[idx][1] && model_valid[idx]) begin
            found              = 1'b1;
            pkt.predictions[i] = 1'b1;
            pkt.next_pc        = model_target[idx];
        end
    end
    return pkt;
endfunction

`endif

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
    import core_pkg::*;
    import bus_pkg::*;
;

    localparam int BTB_ENTRIES = 64;
    localparam int MEM_WORDS   = 256;
    localparam int PACKETS     = 130;
    // Per-packet bound plus loading, readback and training
    localparam int LIMIT_CYCLES = PACKETS * 40 + MEM_WORDS * 16 + 2000;

    logic                      clock;
    logic                      reset;
    logic                      run;
    wb_req_t                   loader_req;
    wb_rsp_t                   loader_rsp;
    branch_update_t [WAYS-1:0] updates;
    logic                      redirect_valid;
    logic [XLEN-1:0]           redirect_pc;
    fetch_packet_t             packet;
    logic                      packet_valid;
    logic                      packet_ready;

    int            errors;
    int            checks;
    int            accepted;
    int            test_errors;
    logic          holding;
    fetch_packet_t held_pkt;
    fetch_packet_t last_pkt;
    fetch_packet_t exp_pkt;

    `include "fetch_model.svh"

    fetch_top #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .MEM_WORDS   (MEM_WORDS)
    ) uut (
        .clock          (clock),
        .reset          (reset),
        .run            (run),
        .loader_req     (loader_req),
        .loader_rsp     (loader_rsp),
        .updates        (updates),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .packet         (packet),
        .packet_valid   (packet_valid),
        .packet_ready   (packet_ready)
    );

    always #20 clock = ~clock;

    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_packet(input fetch_packet_t got, input fetch_packet_t exp);
        check_value("packet.pc", got.pc, exp.pc);
        for (int i = 0; i < WAYS; i++) begin
            check_value($sformatf("packet.insts[%0d]", i), got.insts[i], exp.insts[i]);
        end
        check_value("packet.lane_valid", got.lane_valid, exp.lane_valid);
        check_value("packet.predictions", got.predictions, exp.predictions);
        check_value("packet.next_pc", got.next_pc, exp.next_pc);
    endtask

    // Compare every accepted packet and follow the DUT's path
    always @(posedge clock) begin
        if (reset) begin
            holding = 1'b0;
        end else begin
            if (holding) begin
                check_value("packet_valid (held)", packet_valid, 1'b1);
                check_value("packet (held)", packet, held_pkt);
            end
            if (redirect_valid) begin
                model_pc = redirect_pc;
            end else if (packet_valid && packet_ready) begin
                exp_pkt = expected_packet(model_pc);
                compare_packet(packet, exp_pkt);
                model_pc = exp_pkt.next_pc;
                last_pkt = packet;
                accepted++;
            end
            holding  = packet_valid && !packet_ready && !redirect_valid;
            held_pkt = packet;
        end
    end

    initial begin
        #(LIMIT_CYCLES * 40);
        $display("Watchdog expired: the DUT stopped delivering packets");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic loader_write(input logic [XLEN-1:0] adr, input logic [XLEN-1:0] dat);
        loader_req     = '0;
        loader_req.cyc = 1'b1;
        loader_req.stb = 1'b1;
        loader_req.we  = 1'b1;
        loader_req.adr = adr;
        loader_req.dat = dat;
        do @(posedge clock); while (!loader_rsp.ack);
        #2;
        loader_req = '0;
        model_mem[mem_index(adr)] = dat;
    endtask

    task automatic loader_read(input logic [XLEN-1:0] adr, output logic [XLEN-1:0] dat);
        loader_req     = '0;
        loader_req.cyc = 1'b1;
        loader_req.stb = 1'b1;
        loader_req.adr = adr;
        do @(posedge clock); while (!loader_rsp.ack);
        dat = loader_rsp.dat;
        #2;
        loader_req = '0;
    endtask

    task automatic wait_packets(input int n);
        int target;
        target = accepted + n;
        while (accepted < target) begin
            step();
        end
    endtask

    // Stop fetch and wait until no group is left in flight
    task automatic drain_fetch();
        int quiet;
        run          = 1'b0;
        packet_ready = 1'b1;
        quiet        = 0;
        while (quiet < 8) begin
            step();
            quiet = packet_valid ? 0 : quiet + 1;
        end
    endtask

    task automatic send_update(input branch_update_t u0, input branch_update_t u1);
        updates[0] = u0;
        updates[1] = u1;
        train(u0);
        train(u1);
        step();
        updates = '0;
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] pc);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        step();
        redirect_valid = 1'b0;
    endtask

    task automatic test_done(input int num, input string name);
        $display("Test %0d %s done: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    function automatic branch_update_t make_update(input logic taken,
                                                   input logic [XLEN-1:0] pc,
                                                   input logic [XLEN-1:0] target);
        branch_update_t u;
        u.valid  = 1'b1;
        u.taken  = taken;
        u.pc     = pc;
        u.target = target;
        return u;
    endfunction

    initial begin
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] pcs [6];
        logic [XLEN-1:0] pc0;
        logic [XLEN-1:0] pc1;
        void'($urandom(32'h8bed_7f84));
        clock          = 1'b0;
        reset          = 1'b1;
        run            = 1'b0;
        loader_req     = '0;
        updates        = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        packet_ready   = 1'b1;
        errors         = 0;
        checks         = 0;
        accepted       = 0;
        test_errors    = 0;
        reset_model();
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;

        // Test 1 loads memory, reads it back and fetches in sequence
        for (int w = 0; w < MEM_WORDS; w++) begin
            loader_write(w * 4, $urandom);
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            loader_read(w * 4, data);
            check_value($sformatf("loader read word %0d", w), data, model_mem[w]);
        end
        run = 1'b1;
        wait_packets(12);
        drain_fetch();
        test_done(1, "load and sequential fetch");

        // Test 2 trains a lane-1 branch at 0x104 toward 0x180
        send_update(make_update(1'b1, 32'h104, 32'h180), '0);
        send_update(make_update(1'b1, 32'h104, 32'h180), '0);
        redirect_to(32'h100);
        run = 1'b1;
        wait_packets(1);
        check_value("packet.predictions", last_pkt.predictions, 2'b10);
        check_value("packet.next_pc", last_pkt.next_pc, 32'h180);
        wait_packets(1);
        check_value("packet.pc", last_pkt.pc, 32'h180);
        drain_fetch();
        test_done(2, "training and taken prediction");

        // Test 3 mixes random updates where lane 1 sometimes aliases lane 0
        for (int i = 0; i < 6; i++) begin
            pcs[i] = ($urandom % 64) * 4;
        end
        repeat (24) begin
            pc0 = pcs[$urandom % 6];
            pc1 = ($urandom % 3 == 0) ? pc0 + BTB_ENTRIES * 4 : pcs[$urandom % 6];
            send_update(make_update($urandom % 2, pc0, ($urandom % 64) * 4),
                        make_update($urandom % 2, pc1, ($urandom % 64) * 4));
        end
        redirect_to(32'h0);
        run = 1'b1;
        wait_packets(30);
        drain_fetch();
        repeat (3) send_update(make_update(1'b1, 32'h2f0, 32'h300), '0);
        redirect_to(32'h2f0);
        run = 1'b1;
        wait_packets(1);
        check_value("packet.lane_valid", last_pkt.lane_valid, 2'b01);
        check_value("packet.predictions", last_pkt.predictions, 2'b01);
        drain_fetch();
        test_done(3, "counter saturation");

        // Test 4 with random back-pressure
        redirect_to(32'h0);
        run = 1'b1;
        pc0 = accepted + 40;
        while (accepted < pc0) begin
            packet_ready = ($urandom % 3) != 0;
            step();
        end
        drain_fetch();
        test_done(4, "back-pressure");

        // Test 5 redirects mid-group while the loader writes above the fetch region
        redirect_to(32'h0);
        run = 1'b1;
        fork
            repeat (6) begin
                repeat ($urandom % 5 + 1) step();
                redirect_to(($urandom % 32) * 4);
            end
            for (int k = 0; k < 16; k++) begin
                loader_write(32'h320 + k * 4, $urandom);
            end
        join
        wait_packets(4);
        drain_fetch();
        for (int k = 0; k < 16; k++) begin
            loader_read(32'h320 + k * 4, data);
            check_value("loader read data", data, model_mem[mem_index(32'h320 + k * 4)]);
        end
        test_done(5, "redirect and arbitration");

        $display("%0d checks, %0d errors, %0d packets accepted", checks, errors, accepted);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import core_pkg::*;
    import bus_pkg::*;
#(
    parameter int BTB_ENTRIES = 64,
    parameter int MEM_WORDS   = 256
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      run,
    input  wb_req_t                   loader_req,
    output wb_rsp_t                   loader_rsp,
    input  branch_update_t [WAYS-1:0] updates,
    input  logic                      redirect_valid,
    input  logic [XLEN-1:0]           redirect_pc,
    output fetch_packet_t             packet,
    output logic                      packet_valid,
    input  logic                      packet_ready
);

    logic [XLEN-1:0] pred_pc;
    logic [XLEN-1:0] pred_next_pc;
    logic [WAYS-1:0] pred_taken;
    wb_req_t         fetch_req;
    wb_rsp_t         fetch_rsp;
    wb_req_t         mem_req;
    wb_rsp_t         mem_rsp;

    fetch_unit u_fetch (
        .clock          (clock),
        .reset          (reset),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pred_pc        (pred_pc),
        .pred_next_pc   (pred_next_pc),
        .pred_taken     (pred_taken),
        .bus_req        (fetch_req),
        .bus_rsp        (fetch_rsp),
        .packet         (packet),
        .packet_valid   (packet_valid),
        .packet_ready   (packet_ready)
    );

    branch_pred #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_pred (
        .clock       (clock),
        .reset       (reset),
        .pc          (pred_pc),
        .updates     (updates),
        .next_pc     (pred_next_pc),
        .predictions (pred_taken)
    );

    // Fetch on port 0, loader on port 1
    wb_arbiter u_arb (
        .clock  (clock),
        .reset  (reset),
        .m0_req (fetch_req),
        .m1_req (loader_req),
        .m0_rsp (fetch_rsp),
        .m1_rsp (loader_rsp),
        .s_req  (mem_req),
        .s_rsp  (mem_rsp)
    );

    inst_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clock   (clock),
        .reset   (reset),
        .bus_req (mem_req),
        .bus_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== rtl/inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_mem
    import bus_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clock,
    input  logic    reset,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp
);

    localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    wb_word_t          mem [MEM_WORDS];
    logic [ADDR_W-1:0] word_idx;
    logic              ack;
    logic              access;
    wb_word_t          rdata;

    // Byte address to word index, wrapping at the top
    assign word_idx = ADDR_W'(bus_req.adr[$bits(wb_word_t)-1:2] % MEM_WORDS);

    // A new request is only taken while ack is low
    assign access = bus_req.cyc && bus_req.stb && !ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // Write lands on the same edge that raises ack
    always_ff @(posedge clock) begin
        if (access) begin
            if (bus_req.we) begin
                mem[word_idx] <= bus_req.dat;
            end
            rdata <= mem[word_idx];
        end
    end

    assign bus_rsp.ack = ack;
    assign bus_rsp.dat = rdata;

endmodule

`default_nettype wire

// ==== rtl/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
    import bus_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  wb_req_t m0_req,
    input  wb_req_t m1_req,
    output wb_rsp_t m0_rsp,
    output wb_rsp_t m1_rsp,
    output wb_req_t s_req,
    input  wb_rsp_t s_rsp
);

    // Master 0 is fetch, master 1 the loader
    localparam logic SEL_FETCH  = 1'b0;
    localparam logic SEL_LOADER = 1'b1;

    logic owner;
    logic locked;
    logic owner_cyc;
    logic grant;

    assign owner_cyc = (owner == SEL_LOADER) ? m1_req.cyc : m0_req.cyc;

    // Owner keeps the bus until it drops cyc
    always_comb begin
        if (locked && owner_cyc) begin
            grant = owner;
        end else if (m1_req.cyc) begin
            grant = SEL_LOADER;
        end else begin
            grant = SEL_FETCH;
        end
    end

    assign s_req = (grant == SEL_LOADER) ? m1_req : m0_req;

    // Read data is shared, only ack is steered
    always_comb begin
        m0_rsp     = s_rsp;
        m1_rsp     = s_rsp;
        m0_rsp.ack = s_rsp.ack && (grant == SEL_FETCH);
        m1_rsp.ack = s_rsp.ack && (grant == SEL_LOADER);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            owner  <= SEL_FETCH;
            locked <= 1'b0;
        end else begin
            owner  <= grant;
            locked <= s_req.cyc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import core_pkg::*;
    import bus_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            run,
    input  logic            redirect_valid,
    input  logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] pred_pc,
    input  logic [XLEN-1:0] pred_next_pc,
    input  logic [WAYS-1:0] pred_taken,
    output wb_req_t         bus_req,
    input  wb_rsp_t         bus_rsp,
    output fetch_packet_t   packet,
    output logic            packet_valid,
    input  logic            packet_ready
);

    localparam int LANE_W = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(WAYS - 1);

    // HOLD finishes a beat whose group was killed by a redirect
    typedef enum logic [1:0] {
        IDLE,
        READ,
        HOLD,
        FULL
    } state_t;

    state_t            state;
    logic [XLEN-1:0]   pc;
    logic [LANE_W-1:0] lane;
    logic [XLEN-1:0]   beat_adr;
    logic              in_beat;
    logic              last_lane;
    logic [WAYS-1:0]   lane_mask;

    assign in_beat      = (state == READ) || (state == HOLD);
    assign last_lane    = (lane == LAST_LANE);
    assign packet_valid = (state == FULL);
    assign pred_pc      = pc;

    // Single word reads, cyc stays up across the beats of a group
    always_comb begin
        bus_req     = '0;
        bus_req.cyc = in_beat;
        bus_req.stb = in_beat;
        bus_req.adr = beat_adr;
    end

    // Kill every lane behind a predicted-taken one
    always_comb begin
        lane_mask[0] = 1'b1;
        for (int i = 1; i < WAYS; i++) begin
            lane_mask[i] = lane_mask[i-1] && !pred_taken[i-1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            pc    <= '0;
            lane  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (redirect_valid) begin
                        pc <= redirect_pc;
                    end else if (run) begin
                        state <= READ;
                        lane  <= '0;
                    end
                end
                READ: begin
                    if (redirect_valid) begin
                        pc    <= redirect_pc;
                        state <= bus_rsp.ack ? IDLE : HOLD;
                    end else if (bus_rsp.ack) begin
                        if (last_lane) begin
                            state <= FULL;
                        end else begin
                            lane <= lane + LANE_W'(1);
                        end
                    end
                end
                HOLD: begin
                    if (redirect_valid) begin
                        pc <= redirect_pc;
                    end
                    if (bus_rsp.ack) begin
                        state <= IDLE;
                    end
                end
                FULL: begin
                    // Redirect drops the packet even when it is taken now
                    if (redirect_valid) begin
                        pc    <= redirect_pc;
                        state <= IDLE;
                    end else if (packet_ready) begin
                        pc    <= packet.next_pc;
                        lane  <= '0;
                        state <= run ? READ : IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Bus address and lane buffer
    always_ff @(posedge clock) begin
        if (state == IDLE) begin
            beat_adr <= pc;
        end else if (state == FULL) begin
            beat_adr <= packet.next_pc;
        end else if (state == READ && bus_rsp.ack) begin
            beat_adr <= beat_adr + XLEN'(4);
        end

        if (state == READ && bus_rsp.ack) begin
            packet.insts[lane] <= bus_rsp.dat;
            // Prediction is sampled on the last beat of the group
            if (last_lane) begin
                packet.pc          <= pc;
                packet.next_pc     <= pred_next_pc;
                packet.predictions <= pred_taken;
                packet.lane_valid  <= lane_mask;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branch_pred.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_pred
    import core_pkg::*;
#(
    parameter int BTB_ENTRIES = 64
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [XLEN-1:0]               pc,
    input  branch_update_t [WAYS-1:0]     updates,
    output logic [XLEN-1:0]               next_pc,
    output logic [WAYS-1:0]               predictions
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    // Targets carry no reset, the valid bits guard them
    logic [XLEN-1:0]               btb_target [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0]        btb_valid;
    logic [BTB_ENTRIES-1:0]        valid_next;
    logic [BTB_ENTRIES-1:0][1:0]   pht;
    logic [BTB_ENTRIES-1:0][1:0]   pht_next;
    logic [IDX_W-1:0]              base_idx;

    // Word address of the group start, modulo table size
    assign base_idx = pc[IDX_W+1:2];

    // Lowest lane with a strong counter and a valid target wins
    always_comb begin
        logic [IDX_W-1:0] idx;
        logic             found;
        next_pc     = pc + XLEN'(4 * WAYS);
        predictions = '0;
        found       = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            idx = base_idx + IDX_W'(i);
            if (!found && pht[idx][1] && btb_valid[idx]) begin
                found          = 1'b1;
                next_pc        = btb_target[idx];
                predictions[i] = 1'b1;
            end
        end
    end

    // Lanes applied in order so two updates to one entry both count
    always_comb begin
        logic [IDX_W-1:0] idx;
        pht_next   = pht;
        valid_next = btb_valid;
        for (int i = 0; i < WAYS; i++) begin
            idx = updates[i].pc[IDX_W+1:2];
            if (updates[i].valid) begin
                if (updates[i].taken) begin
                    valid_next[idx] = 1'b1;
                    if (pht_next[idx] != 2'b11) begin
                        pht_next[idx] = pht_next[idx] + 2'd1;
                    end
                end else if (pht_next[idx] != 2'b00) begin
                    pht_next[idx] = pht_next[idx] - 2'd1;
                end
            end
        end
    end

    // Counters start weakly not taken
    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
            pht       <= {BTB_ENTRIES{2'b01}};
        end else begin
            btb_valid <= valid_next;
            pht       <= pht_next;
        end
    end

    // Later lane overwrites an earlier one on the same index
    always_ff @(posedge clock) begin
        for (int i = 0; i < WAYS; i++) begin
            if (updates[i].valid && updates[i].taken) begin
                btb_target[updates[i].pc[IDX_W+1:2]] <= updates[i].target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    import core_pkg::*;

    // Address and data words on the instruction bus
    typedef logic [XLEN-1:0] wb_word_t;

    // Master to slave, Wishbone classic
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        // Byte address, word aligned
        wb_word_t adr;
        wb_word_t dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic     ack;
        wb_word_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Machine word and fetch group size
    localparam int XLEN = 32;
    localparam int WAYS = 2;

    // One fetch group as handed downstream
    typedef struct packed {
        logic [XLEN-1:0]           pc;
        logic [WAYS-1:0][XLEN-1:0] insts;
        // Lanes past a predicted-taken lane are cleared
        logic [WAYS-1:0]           lane_valid;
        // One-hot or zero
        logic [WAYS-1:0]           predictions;
        logic [XLEN-1:0]           next_pc;
    } fetch_packet_t;

    // Committed outcome of one branch lane
    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
    } branch_update_t;

endpackage

`default_nettype wire
